// File: pipe_pkg.sv
package pipe_pkg;

    // data path word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // decoded micro-op as it reaches writeback
    typedef logic [7:0] uop_t;

    // condition sub-field of the micro-op
    typedef logic [3:0] cond_t;

    // flag positions inside uop_t
    localparam int unsigned uop_csr_bit = 0;
    localparam int unsigned uop_div_bit = 1;
    localparam int unsigned uop_mem_bit = 2;

    // cond_t sits in uop_t[7:4]
    localparam int unsigned uop_cond_lsb = 4;

    // cond bit 0 set picks the remainder of a divide
    localparam int unsigned cond_rem_bit = 0;

    // cond bit 2 clear on a memory uop means load
    localparam int unsigned cond_store_bit = 2;

endpackage

// File: exc_pkg.sv
package exc_pkg;

    // exception code as carried down the pipe
    typedef logic [6:0] ecode_t;

    // virtual page number, low bits of the bad address
    typedef logic [18:0] vppn_t;

    // interrupt
    localparam ecode_t exp_int = 7'h00;

    // page invalid on load, store, fetch
    localparam ecode_t exp_pil = 7'h01;
    localparam ecode_t exp_pis = 7'h02;
    localparam ecode_t exp_pif = 7'h03;

    // page modify
    localparam ecode_t exp_pme = 7'h04;

    // page privilege
    localparam ecode_t exp_ppi = 7'h07;

    // fetch address error
    localparam ecode_t exp_adef = 7'h08;

    // misaligned access
    localparam ecode_t exp_ale = 7'h09;

    // TLB refill, taken through its own entry
    localparam ecode_t exp_tlbr = 7'h3f;

endpackage

// File: div_unit.sv
`timescale 1ns/1ns
module div_unit (
    input  logic            clk,
    input  logic            aresetn,
    input  logic            div_req,
    input  pipe_pkg::word_t div_dividend,
    input  pipe_pkg::word_t div_divisor,
    output logic            div_ack,
    output pipe_pkg::word_t div_quotient,
    output pipe_pkg::word_t div_remainder
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_t;

    state_t      state;
    logic [4:0]  iter;
    word_t       divisor_q;
    logic [32:0] partial;
    logic [32:0] diff;
    logic        fits;

    // quotient register doubles as the dividend shift source
    assign partial = {div_remainder, div_quotient[31]};
    assign diff    = partial - {1'b0, divisor_q};
    assign fits    = partial >= {1'b0, divisor_q};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= st_idle;
            iter    <= '0;
            div_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (div_req) begin
                        state <= st_busy;
                        iter  <= '0;
                    end
                end
                st_busy: begin
                    iter <= iter + 5'd1;
                    if (iter == 5'd31) begin
                        state   <= st_done;
                        div_ack <= 1'b1;
                    end
                end
                st_done: begin
                    // hold results until the requester drops req
                    if (!div_req) begin
                        state   <= st_idle;
                        div_ack <= 1'b0;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // zero divisor falls out as all-ones quotient and remainder = dividend
    always_ff @(posedge clk) begin
        if (state == st_idle && div_req) begin
            div_quotient  <= div_dividend;
            div_remainder <= '0;
            divisor_q     <= div_divisor;
        end else if (state == st_busy) begin
            div_remainder <= fits ? diff[31:0] : partial[31:0];
            div_quotient  <= {div_quotient[30:0], fits};
        end
    end

    assert property (@(posedge clk) disable iff (!aresetn)
        div_ack && $past(div_ack) |-> $stable(div_quotient) && $stable(div_remainder))
        else $error("divider results changed while div_ack is high");

endmodule

// File: reg_file.sv
`timescale 1ns/1ns
module reg_file (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               we0,
    input  logic               we1,
    input  pipe_pkg::reg_idx_t waddr0,
    input  pipe_pkg::reg_idx_t waddr1,
    input  pipe_pkg::word_t    wdata0,
    input  pipe_pkg::word_t    wdata1,
    input  pipe_pkg::reg_idx_t raddr0,
    input  pipe_pkg::reg_idx_t raddr1,
    output pipe_pkg::word_t    rdata0,
    output pipe_pkg::word_t    rdata1
);
    import pipe_pkg::*;

    word_t regs [2**$bits(reg_idx_t)];

    // r0 leaves reset as zero and no write port reaches it
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            regs[0] <= '0;
        end else begin
            // port 1 is the younger instruction, so its write lands last
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

    assert property (@(posedge clk) disable iff (!aresetn)
        ((we0 && waddr0 == '0) || (we1 && waddr1 == '0)) && raddr0 == '0
        |=> raddr0 != '0 || rdata0 == '0)
        else $error("write to r0 became visible on a read port");

endmodule

// File: wb_result_select.sv
`timescale 1ns/1ns
module wb_result_select (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              inst_valid0,
    input  logic              inst_valid1,
    input  pipe_pkg::uop_t    uop0,
    input  pipe_pkg::uop_t    uop1,
    input  pipe_pkg::reg_idx_t rd0,
    input  pipe_pkg::reg_idx_t rd1,
    input  pipe_pkg::word_t   result0,
    input  pipe_pkg::word_t   result1,
    input  logic              result_valid0,
    input  logic              result_valid1,
    input  pipe_pkg::word_t   div_a0,
    input  pipe_pkg::word_t   div_a1,
    input  pipe_pkg::word_t   div_b0,
    input  pipe_pkg::word_t   div_b1,
    input  pipe_pkg::word_t   dcache_data,
    input  logic              dcache_ready,
    input  pipe_pkg::word_t   csr_data,
    input  logic              csr_ready,
    input  logic              div_ack,
    input  pipe_pkg::word_t   div_quotient,
    input  pipe_pkg::word_t   div_remainder,
    output logic              allowin,
    output logic              div_req,
    output pipe_pkg::word_t   div_dividend,
    output pipe_pkg::word_t   div_divisor,
    output logic              wb_we0,
    output logic              wb_we1,
    output pipe_pkg::reg_idx_t wb_rd0,
    output pipe_pkg::reg_idx_t wb_rd1,
    output pipe_pkg::word_t   wb_data0,
    output pipe_pkg::word_t   wb_data1
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        div_idle,
        div_wait,
        div_release
    } div_state_t;

    div_state_t div_state;
    logic       div_owner;
    logic       div_done0;
    word_t      div_hold0;

    cond_t cond0;
    cond_t cond1;
    logic  need_div0;
    logic  need_div1;
    logic  start_div;
    logic  div_capture;
    logic  park0;
    word_t div_pick0;
    word_t div_pick1;
    logic  ready0;
    logic  ready1;
    word_t data0;
    word_t data1;

    assign cond0 = uop0[uop_cond_lsb +: $bits(cond_t)];
    assign cond1 = uop1[uop_cond_lsb +: $bits(cond_t)];

    // divide is the source only when nothing ahead of it in priority applies
    assign need_div0 = inst_valid0 & ~result_valid0 & ~uop0[uop_csr_bit]
                     & uop0[uop_div_bit] & ~div_done0;
    assign need_div1 = inst_valid1 & ~result_valid1 & uop1[uop_div_bit];

    assign start_div   = (div_state == div_idle) & (need_div0 | need_div1);
    assign div_capture = (div_state == div_wait) & div_ack;

    // lane 0 result is parked when lane 1 still waits for its own divide
    assign park0 = div_capture & ~div_owner & need_div1;

    assign div_pick0 = cond0[cond_rem_bit] ? div_remainder : div_quotient;
    assign div_pick1 = cond1[cond_rem_bit] ? div_remainder : div_quotient;

    always_comb begin
        ready0 = 1'b0;
        data0  = result0;
        if (result_valid0) begin
            ready0 = 1'b1;
        end else if (uop0[uop_csr_bit]) begin
            ready0 = csr_ready;
            data0  = csr_data;
        end else if (uop0[uop_div_bit]) begin
            ready0 = div_done0 | (div_capture & ~div_owner);
            data0  = div_done0 ? div_hold0 : div_pick0;
        end else if (uop0[uop_mem_bit] && !cond0[cond_store_bit]) begin
            ready0 = dcache_ready;
            data0  = dcache_data;
        end
    end

    // no CSR path on lane 1
    always_comb begin
        ready1 = 1'b0;
        data1  = result1;
        if (result_valid1) begin
            ready1 = 1'b1;
        end else if (uop1[uop_div_bit]) begin
            ready1 = div_capture & div_owner;
            data1  = div_pick1;
        end else if (uop1[uop_mem_bit] && !cond1[cond_store_bit]) begin
            ready1 = dcache_ready;
            data1  = dcache_data;
        end
    end

    assign allowin = (~inst_valid0 | ready0) & (~inst_valid1 | ready1);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            div_state <= div_idle;
            div_req   <= 1'b0;
            div_owner <= 1'b0;
            div_done0 <= 1'b0;
            wb_we0    <= 1'b0;
            wb_we1    <= 1'b0;
        end else begin
            wb_we0 <= allowin & inst_valid0 & ready0;
            wb_we1 <= allowin & inst_valid1 & ready1;
            if (allowin) begin
                div_done0 <= 1'b0;
            end
            case (div_state)
                div_idle: begin
                    // lane 0 goes first
                    if (start_div) begin
                        div_req   <= 1'b1;
                        div_owner <= ~need_div0;
                        div_state <= div_wait;
                    end
                end
                div_wait: begin
                    if (park0) begin
                        div_done0 <= 1'b1;
                        div_req   <= 1'b0;
                        div_state <= div_release;
                    end else if (div_ack && allowin) begin
                        div_req   <= 1'b0;
                        div_state <= div_release;
                    end
                end
                div_release: begin
                    if (!div_ack) begin
                        div_state <= div_idle;
                    end
                end
                default: begin
                    div_state <= div_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_div) begin
            div_dividend <= need_div0 ? div_a0 : div_a1;
            div_divisor  <= need_div0 ? div_b0 : div_b1;
        end
        if (park0) begin
            div_hold0 <= div_pick0;
        end
        wb_rd0   <= rd0;
        wb_rd1   <= rd1;
        wb_data0 <= data0;
        wb_data1 <= data1;
    end

    // new request only after the divider has let go of the last one
    assert property (@(posedge clk) disable iff (!aresetn) $rose(div_req) |-> !div_ack)
        else $error("div_req raised while div_ack is still high");

endmodule

// File: wb_exception_commit.sv
`timescale 1ns/1ns
module wb_exception_commit (
    input  logic             clk,
    input  logic             aresetn,
    input  exc_pkg::ecode_t  ecode_in,
    input  logic             exception_flag_in,
    input  pipe_pkg::word_t  badv_in,
    input  pipe_pkg::word_t  era_in,
    input  logic             cpu_interrupt,
    input  pipe_pkg::word_t  eentry,
    input  pipe_pkg::word_t  tlbrentry,
    output logic             flush,
    output exc_pkg::ecode_t  ecode_out,
    output pipe_pkg::word_t  badv_out,
    output logic             wen_badv,
    output pipe_pkg::word_t  era_out,
    output logic             wen_era,
    output exc_pkg::vppn_t   vppn_out,
    output logic             wen_vppn,
    output logic             tlb_exception,
    output pipe_pkg::word_t  redirect_pc
);
    import exc_pkg::*;

    logic set_vppn;
    logic set_badv;
    logic take;

    // address-translation faults carry a page number
    assign set_vppn = ecode_in inside {exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi, exp_tlbr};

    // plus the pure address errors for BADV
    assign set_badv = set_vppn | (ecode_in inside {exp_adef, exp_ale});

    assign take = exception_flag_in | cpu_interrupt;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush         <= 1'b0;
            wen_era       <= 1'b0;
            wen_badv      <= 1'b0;
            wen_vppn      <= 1'b0;
            tlb_exception <= 1'b0;
        end else begin
            flush         <= take;
            wen_era       <= take;
            wen_badv      <= exception_flag_in & set_badv;
            wen_vppn      <= exception_flag_in & set_vppn;
            tlb_exception <= exception_flag_in & (ecode_in == exp_tlbr);
        end
    end

    always_ff @(posedge clk) begin
        // interrupt alone reports code zero
        if (cpu_interrupt && !exception_flag_in) begin
            ecode_out <= exp_int;
        end else begin
            ecode_out <= ecode_in;
        end
        badv_out <= badv_in;
        era_out  <= era_in;
        vppn_out <= badv_in[$bits(vppn_t)-1:0];
    end

    // refill goes to its own handler
    assign redirect_pc = tlb_exception ? tlbrentry : eentry;

endmodule

// File: wb_top.sv
`timescale 1ns/1ns
module wb_top (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               inst_valid0,
    input  logic               inst_valid1,
    input  pipe_pkg::uop_t     uop0,
    input  pipe_pkg::uop_t     uop1,
    input  pipe_pkg::reg_idx_t rd0,
    input  pipe_pkg::reg_idx_t rd1,
    input  pipe_pkg::word_t    result0,
    input  pipe_pkg::word_t    result1,
    input  logic               result_valid0,
    input  logic               result_valid1,
    input  pipe_pkg::word_t    div_a0,
    input  pipe_pkg::word_t    div_a1,
    input  pipe_pkg::word_t    div_b0,
    input  pipe_pkg::word_t    div_b1,
    input  pipe_pkg::word_t    dcache_data,
    input  logic               dcache_ready,
    input  pipe_pkg::word_t    csr_data,
    input  logic               csr_ready,
    input  exc_pkg::ecode_t    ecode_in,
    input  logic               exception_flag_in,
    input  pipe_pkg::word_t    badv_in,
    input  pipe_pkg::word_t    era_in,
    input  logic               cpu_interrupt,
    input  pipe_pkg::word_t    eentry,
    input  pipe_pkg::word_t    tlbrentry,
    input  pipe_pkg::reg_idx_t rf_raddr0,
    input  pipe_pkg::reg_idx_t rf_raddr1,
    output logic               allowin,
    output logic               wb_we0,
    output logic               wb_we1,
    output pipe_pkg::reg_idx_t wb_rd0,
    output pipe_pkg::reg_idx_t wb_rd1,
    output pipe_pkg::word_t    wb_data0,
    output pipe_pkg::word_t    wb_data1,
    output pipe_pkg::word_t    rf_rdata0,
    output pipe_pkg::word_t    rf_rdata1,
    output logic               flush,
    output exc_pkg::ecode_t    ecode_out,
    output pipe_pkg::word_t    badv_out,
    output logic               wen_badv,
    output pipe_pkg::word_t    era_out,
    output logic               wen_era,
    output exc_pkg::vppn_t     vppn_out,
    output logic               wen_vppn,
    output logic               tlb_exception,
    output pipe_pkg::word_t    redirect_pc
);
    import pipe_pkg::*;

    // divider handshake
    logic  div_req;
    logic  div_ack;
    word_t div_dividend;
    word_t div_divisor;
    word_t div_quotient;
    word_t div_remainder;

    wb_result_select u_select (
        .clk(clk), .aresetn(aresetn),
        .inst_valid0(inst_valid0), .inst_valid1(inst_valid1),
        .uop0(uop0), .uop1(uop1), .rd0(rd0), .rd1(rd1),
        .result0(result0), .result1(result1),
        .result_valid0(result_valid0), .result_valid1(result_valid1),
        .div_a0(div_a0), .div_a1(div_a1), .div_b0(div_b0), .div_b1(div_b1),
        .dcache_data(dcache_data), .dcache_ready(dcache_ready),
        .csr_data(csr_data), .csr_ready(csr_ready),
        .div_ack(div_ack), .div_quotient(div_quotient), .div_remainder(div_remainder),
        .allowin(allowin), .div_req(div_req),
        .div_dividend(div_dividend), .div_divisor(div_divisor),
        .wb_we0(wb_we0), .wb_we1(wb_we1), .wb_rd0(wb_rd0), .wb_rd1(wb_rd1),
        .wb_data0(wb_data0), .wb_data1(wb_data1)
    );

    div_unit u_div (
        .clk(clk), .aresetn(aresetn),
        .div_req(div_req), .div_dividend(div_dividend), .div_divisor(div_divisor),
        .div_ack(div_ack), .div_quotient(div_quotient), .div_remainder(div_remainder)
    );

    wb_exception_commit u_commit (
        .clk(clk), .aresetn(aresetn),
        .ecode_in(ecode_in), .exception_flag_in(exception_flag_in),
        .badv_in(badv_in), .era_in(era_in), .cpu_interrupt(cpu_interrupt),
        .eentry(eentry), .tlbrentry(tlbrentry),
        .flush(flush), .ecode_out(ecode_out),
        .badv_out(badv_out), .wen_badv(wen_badv),
        .era_out(era_out), .wen_era(wen_era),
        .vppn_out(vppn_out), .wen_vppn(wen_vppn),
        .tlb_exception(tlb_exception), .redirect_pc(redirect_pc)
    );

    reg_file u_rf (
        .clk(clk), .aresetn(aresetn),
        .we0(wb_we0), .we1(wb_we1),
        .waddr0(wb_rd0), .waddr1(wb_rd1),
        .wdata0(wb_data0), .wdata1(wb_data1),
        .raddr0(rf_raddr0), .raddr1(rf_raddr1),
        .rdata0(rf_rdata0), .rdata1(rf_rdata1)
    );

endmodule

// File: tb_wb_top.sv
`timescale 1ns/1ns
module tb_wb_top;
    import pipe_pkg::*;
    import exc_pkg::*;

    typedef struct packed {
        logic       is_exc;
        logic       v0, v1, rv0, rv1;
        uop_t       uop0, uop1;
        reg_idx_t   rd0, rd1;
        word_t      res0, res1, a0, b0, a1, b1, dc_data, csr_val;
        logic [7:0] delay;
        logic       we0, we1;
        word_t      exp0, exp1;
        ecode_t     ecode;
        logic       exc, irq;
        word_t      badv, era;
        logic       exp_flush, exp_badv, exp_vppn, exp_tlb;
        ecode_t     exp_ecode;
    } entry_t;

    logic clk = 1'b0;
    logic aresetn;
    logic inst_valid0, inst_valid1, result_valid0, result_valid1;
    uop_t uop0, uop1;
    reg_idx_t rd0, rd1, rf_raddr0, rf_raddr1, wb_rd0, wb_rd1;
    word_t result0, result1, div_a0, div_a1, div_b0, div_b1;
    word_t dcache_data, csr_data, badv_in, era_in, eentry, tlbrentry;
    logic dcache_ready, csr_ready, exception_flag_in, cpu_interrupt;
    ecode_t ecode_in, ecode_out;
    logic allowin, wb_we0, wb_we1, flush, wen_badv, wen_era, wen_vppn, tlb_exception;
    word_t wb_data0, wb_data1, rf_rdata0, rf_rdata1, badv_out, era_out, redirect_pc;
    vppn_t vppn_out;

    entry_t table_q[$];
    logic   table_ready = 1'b0;

    wb_top u_wb_top (.*);

    always #2 clk = ~clk;

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_ecode(input string what, input ecode_t got, input ecode_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_vppn(input string what, input vppn_t got, input vppn_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %0d got %0d", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s expected %b got %b", $time, what, exp, got);
            fail_run();
        end
    endtask

    function automatic uop_t make_uop(input logic csr, input logic div, input logic mem,
                                      input cond_t cond);
        uop_t u;
        u = '0;
        u[uop_csr_bit] = csr;
        u[uop_div_bit] = div;
        u[uop_mem_bit] = mem;
        u[uop_cond_lsb +: $bits(cond_t)] = cond;
        return u;
    endfunction

    // unsigned rule, zero divisor gives all ones and the dividend back
    function automatic word_t expected_div(input word_t a, input word_t b, input logic rem);
        if (b == 32'd0) begin
            return rem ? a : 32'hffff_ffff;
        end
        return rem ? a % b : a / b;
    endfunction

    function automatic logic page_fault(input ecode_t code);
        case (code)
            exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi, exp_tlbr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t rf_expect(input entry_t e, input reg_idx_t idx);
        if (idx == 5'd0) begin
            return 32'd0;
        end
        if (e.we1 && e.rd1 == idx) begin
            return e.exp1;
        end
        return e.exp0;
    endfunction

    function automatic entry_t blank_entry();
        entry_t e;
        e = '0;
        e.res0 = $urandom;
        e.res1 = $urandom;
        e.a0 = $urandom;
        e.a1 = $urandom;
        e.b0 = $urandom >> ($urandom % 28);
        e.b1 = $urandom >> ($urandom % 28);
        e.dc_data = $urandom;
        e.csr_val = $urandom;
        e.rd0 = reg_idx_t'(1 + $urandom % 31);
        e.rd1 = reg_idx_t'(1 + $urandom % 31);
        return e;
    endfunction

    task automatic add_exec(input reg_idx_t r0, input reg_idx_t r1, input logic v0,
                            input logic v1);
        entry_t e;
        e = blank_entry();
        e.v0 = v0;
        e.v1 = v1;
        e.rv0 = v0;
        e.rv1 = v1;
        e.rd0 = r0;
        e.rd1 = r1;
        e.we0 = v0;
        e.we1 = v1;
        e.exp0 = e.res0;
        e.exp1 = e.res1;
        table_q.push_back(e);
    endtask

    // lane 2 means both lanes load
    task automatic add_src(input logic [1:0] lane, input logic is_csr, input logic [7:0] delay);
        entry_t e;
        e = blank_entry();
        e.v0 = 1'b1;
        e.v1 = 1'b1;
        e.we0 = 1'b1;
        e.we1 = 1'b1;
        e.delay = delay;
        e.exp0 = e.res0;
        e.exp1 = e.res1;
        if (lane == 2'd0 && is_csr) begin
            e.uop0 = make_uop(1'b1, 1'b0, 1'b0, cond_t'($urandom));
            e.exp0 = e.csr_val;
        end else if (lane != 2'd1) begin
            e.uop0 = make_uop(1'b0, 1'b0, 1'b1, cond_t'($urandom) & 4'hb);
            e.exp0 = e.dc_data;
        end else begin
            e.rv0 = 1'b1;
        end
        if (lane == 2'd0) begin
            e.rv1 = 1'b1;
        end else begin
            e.uop1 = make_uop(1'b0, 1'b0, 1'b1, cond_t'($urandom) & 4'hb);
            e.exp1 = e.dc_data;
        end
        table_q.push_back(e);
    endtask

    task automatic add_div(input logic d0, input logic d1, input logic zero0, input logic zero1);
        entry_t e;
        cond_t  c0;
        cond_t  c1;
        e = blank_entry();
        c0 = cond_t'($urandom);
        c1 = cond_t'($urandom);
        e.v0 = 1'b1;
        e.v1 = 1'b1;
        e.we0 = 1'b1;
        e.we1 = 1'b1;
        e.rv0 = ~d0;
        e.rv1 = ~d1;
        e.b0 = zero0 ? 32'd0 : e.b0;
        e.b1 = zero1 ? 32'd0 : e.b1;
        e.uop0 = make_uop(1'b0, d0, 1'b0, c0);
        e.uop1 = make_uop(1'b0, d1, 1'b0, c1);
        e.exp0 = d0 ? expected_div(e.a0, e.b0, c0[0]) : e.res0;
        e.exp1 = d1 ? expected_div(e.a1, e.b1, c1[0]) : e.res1;
        table_q.push_back(e);
    endtask

    task automatic add_exc(input ecode_t code, input logic exc, input logic irq);
        entry_t e;
        e = blank_entry();
        e.is_exc = 1'b1;
        e.ecode = code;
        e.exc = exc;
        e.irq = irq;
        e.badv = $urandom;
        e.era = $urandom;
        e.exp_flush = exc | irq;
        e.exp_vppn = exc & page_fault(code);
        e.exp_badv = exc & (page_fault(code) | code == exp_adef | code == exp_ale);
        e.exp_tlb = exc & (code == exp_tlbr);
        e.exp_ecode = (irq && !exc) ? exp_int : code;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_exec(5'd3, 5'd9, 1'b1, 1'b1);
        add_exec(5'd0, 5'd7, 1'b1, 1'b1);
        add_exec(5'd12, 5'd12, 1'b1, 1'b1);
        add_exec(5'd0, 5'd20, 1'b0, 1'b1);
        add_exec(5'd14, 5'd0, 1'b1, 1'b0);
        add_src(2'd0, 1'b0, 8'd3);
        add_src(2'd0, 1'b1, 8'd4);
        add_src(2'd1, 1'b0, 8'd2);
        add_src(2'd2, 1'b0, 8'd1);
        add_src(2'd0, 1'b1, 8'd0);
        for (int i = 0; i < 4; i++) begin
            add_div(1'b1, 1'b0, 1'b0, 1'b0);
        end
        add_div(1'b0, 1'b1, 1'b0, 1'b0);
        add_div(1'b1, 1'b0, 1'b1, 1'b0);
        add_div(1'b0, 1'b1, 1'b0, 1'b1);
        add_div(1'b1, 1'b1, 1'b0, 1'b0);
        add_div(1'b1, 1'b1, 1'b1, 1'b1);
        add_exc(exp_pil, 1'b1, 1'b0);
        add_exc(exp_pis, 1'b1, 1'b0);
        add_exc(exp_pif, 1'b1, 1'b0);
        add_exc(exp_pme, 1'b1, 1'b0);
        add_exc(exp_ppi, 1'b1, 1'b0);
        add_exc(exp_adef, 1'b1, 1'b0);
        add_exc(exp_ale, 1'b1, 1'b0);
        add_exc(exp_tlbr, 1'b1, 1'b0);
        // syscall-like code outside both fault sets
        add_exc(7'h0b, 1'b1, 1'b0);
        add_exc(exp_ale, 1'b0, 1'b1);
        add_exc(exp_tlbr, 1'b0, 1'b0);
    endtask

    task automatic apply_inst(input entry_t e);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        inst_valid0 = e.v0;
        inst_valid1 = e.v1;
        uop0 = e.uop0;
        uop1 = e.uop1;
        rd0 = e.rd0;
        rd1 = e.rd1;
        result0 = e.res0;
        result1 = e.res1;
        result_valid0 = e.rv0;
        result_valid1 = e.rv1;
        div_a0 = e.a0;
        div_b0 = e.b0;
        div_a1 = e.a1;
        div_b1 = e.b1;
        dcache_data = e.dc_data;
        csr_data = e.csr_val;
        dcache_ready = (e.delay == 8'd0);
        csr_ready = (e.delay == 8'd0);
        #1;
        if (e.delay != 8'd0) begin
            check_bit("allowin with source not ready", allowin, 1'b0);
        end
        while (!allowin) begin
            @(negedge clk);
            check_bit("wb_we0 during stall", wb_we0, 1'b0);
            check_bit("wb_we1 during stall", wb_we1, 1'b0);
            waited++;
            if (waited >= e.delay) begin
                dcache_ready = 1'b1;
                csr_ready = 1'b1;
            end
            #1;
        end
        @(negedge clk);
        check_bit("wb_we0", wb_we0, e.we0);
        check_bit("wb_we1", wb_we1, e.we1);
        if (e.we0) begin
            check_idx("wb_rd0", wb_rd0, e.rd0);
            check_word("wb_data0", wb_data0, e.exp0);
        end
        if (e.we1) begin
            check_idx("wb_rd1", wb_rd1, e.rd1);
            check_word("wb_data1", wb_data1, e.exp1);
        end
        inst_valid0 = 1'b0;
        inst_valid1 = 1'b0;
        result_valid0 = 1'b0;
        result_valid1 = 1'b0;
        dcache_ready = 1'b0;
        csr_ready = 1'b0;
        rf_raddr0 = e.rd0;
        rf_raddr1 = e.rd1;
        @(negedge clk);
        if (e.we0) begin
            check_word("rf_rdata0", rf_rdata0, rf_expect(e, e.rd0));
        end
        if (e.we1) begin
            check_word("rf_rdata1", rf_rdata1, rf_expect(e, e.rd1));
        end
    endtask

    task automatic apply_exc(input entry_t e);
        @(negedge clk);
        ecode_in = e.ecode;
        exception_flag_in = e.exc;
        cpu_interrupt = e.irq;
        badv_in = e.badv;
        era_in = e.era;
        @(negedge clk);
        check_bit("flush", flush, e.exp_flush);
        check_bit("wen_era", wen_era, e.exp_flush);
        check_bit("wen_badv", wen_badv, e.exp_badv);
        check_bit("wen_vppn", wen_vppn, e.exp_vppn);
        check_bit("tlb_exception", tlb_exception, e.exp_tlb);
        check_ecode("ecode_out", ecode_out, e.exp_ecode);
        check_vppn("vppn_out", vppn_out, e.badv[$bits(vppn_t)-1:0]);
        check_word("badv_out", badv_out, e.badv);
        check_word("era_out", era_out, e.era);
        check_word("redirect_pc", redirect_pc, e.exp_tlb ? tlbrentry : eentry);
        exception_flag_in = 1'b0;
        cpu_interrupt = 1'b0;
    endtask

    initial begin
        wait (table_ready);
        repeat (table_q.size() * 60 + 10) @(posedge clk);
        $display("watchdog expired: the run did not finish within %0d cycles",
                 table_q.size() * 60 + 10);
        fail_run();
    end

    initial begin
        void'($urandom(32'hfbb42496));
        aresetn = 1'b0;
        // inputs held active through reset
        {inst_valid0, inst_valid1, result_valid0, result_valid1} = '1;
        {uop0, uop1, rd0, rd1, rf_raddr0, rf_raddr1} = '0;
        {result0, result1, div_a0, div_a1, div_b0, div_b1} = '0;
        {dcache_data, csr_data, badv_in, era_in} = '0;
        {dcache_ready, csr_ready, cpu_interrupt} = '0;
        exception_flag_in = 1'b1;
        ecode_in = exp_tlbr;
        eentry = $urandom;
        tlbrentry = $urandom;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bit("wb_we0 in reset", wb_we0, 1'b0);
        check_bit("wb_we1 in reset", wb_we1, 1'b0);
        check_bit("flush in reset", flush, 1'b0);
        check_bit("wen_badv in reset", wen_badv, 1'b0);
        check_bit("wen_era in reset", wen_era, 1'b0);
        check_bit("wen_vppn in reset", wen_vppn, 1'b0);
        check_bit("tlb_exception in reset", tlb_exception, 1'b0);
        {inst_valid0, inst_valid1, result_valid0, result_valid1} = '0;
        exception_flag_in = 1'b0;
        ecode_in = '0;
        aresetn = 1'b1;
        for (int i = 0; i < table_q.size(); i++) begin
            if (table_q[i].is_exc) begin
                apply_exc(table_q[i]);
            end else begin
                apply_inst(table_q[i]);
            end
        end
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: all.f
pipe_pkg.sv
exc_pkg.sv
div_unit.sv
reg_file.sv
wb_result_select.sv
wb_exception_commit.sv
wb_top.sv
tb_wb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_wb_top -f all.f --Mdir obj_dir || exit 1
result=$(./obj_dir/Vtb_wb_top 2>&1)
echo "$result"
echo "$result" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
